// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - hw/fetch_pkg.sv
  - hw/pc_select.sv
  - hw/ibus_fetch_fsm.sv
  - hw/fetch_queue.sv
  - hw/fetch_unit.sv
  - target: test
    files:
      - tb/tb_ibus_model.sv
      - tb/tb_fetch_unit.sv

// ==== build.f ====
hw/fetch_pkg.sv
hw/pc_select.sv
hw/ibus_fetch_fsm.sv
hw/fetch_queue.sv
hw/fetch_unit.sv
tb/tb_ibus_model.sv
tb/tb_fetch_unit.sv

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // address or instruction word
    typedef logic [31:0] word_t;

    // pc step per fetch, also the bus read size in bytes
    localparam int unsigned FETCH_BYTES = 8;

    // axi4-lite read address channel, arready travels on its own
    typedef struct packed {
        logic  arvalid;
        word_t araddr;
    } ibus_ar_t;

    // axi4-lite read data channel, 64-bit beat
    typedef struct packed {
        logic        rvalid;
        logic [63:0] rdata;
        logic [1:0]  rresp;
    } ibus_r_t;

    // only one kind active at a time
    typedef enum logic [1:0] {
        redirect_none,
        redirect_branch,
        redirect_exception,
        redirect_eret
    } redirect_kind_t;

    // target unused for the exception kind
    typedef struct packed {
        redirect_kind_t kind;
        word_t          target;
    } redirect_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  addr_exc;
    } fetch_slot_t;

    // index 0 is slot 0, at the fetch pc
    typedef fetch_slot_t [1:0] fetch_pair_t;

endpackage

// ==== hw/fetch_queue.sv ====
module fetch_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   enq_valid,
    input  fetch_pkg::fetch_pair_t enq_pair,
    input  logic                   out_ready,
    output logic                   enq_ready,
    output fetch_pkg::fetch_pair_t out_pair,
    output logic                   out_valid
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::fetch_pair_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   do_enq;
    logic                   do_deq;

    assign enq_ready = (count != CNT_W'(QUEUE_DEPTH));
    assign out_valid = (count != '0);
    assign out_pair  = mem[rd_ptr];

    // nothing moves in a flush cycle
    assign do_enq = enq_valid && enq_ready && !flush;
    assign do_deq = out_valid && out_ready && !flush;

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_pair;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous enq and deq keep the count
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound : assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(QUEUE_DEPTH));

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit #(
    parameter fetch_pkg::word_t RESET_PC    = 32'hbfc0_0000,
    parameter fetch_pkg::word_t EXC_ENTRY   = 32'hbfc0_0380,
    parameter int               QUEUE_DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::redirect_t   redirect,
    output fetch_pkg::ibus_ar_t    ar,
    input  logic                   arready,
    input  fetch_pkg::ibus_r_t     r,
    output logic                   rready,
    output fetch_pkg::fetch_pair_t out_pair,
    output logic                   out_valid,
    input  logic                   out_ready
);

    // pc side
    fetch_pkg::word_t       pc;
    logic                   pc_misaligned;
    logic                   halted;
    logic                   flush;
    logic                   pc_take;
    // fsm to queue
    logic                   enq_valid;
    logic                   enq_ready;
    fetch_pkg::fetch_pair_t enq_pair;

    pc_select #(
        .RESET_PC (RESET_PC),
        .EXC_ENTRY(EXC_ENTRY)
    ) pc_select_i (
        .clk, .reset, .redirect, .pc_take,
        .pc, .pc_misaligned, .halted, .flush
    );

    ibus_fetch_fsm ibus_fetch_fsm_i (
        .clk, .reset,
        .pc, .pc_misaligned, .halted, .flush,
        .arready, .r, .enq_ready,
        .pc_take, .ar, .rready, .enq_valid, .enq_pair
    );

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) fetch_queue_i (
        .clk, .reset, .flush,
        .enq_valid, .enq_pair, .out_ready,
        .enq_ready, .out_pair, .out_valid
    );

endmodule

// ==== hw/ibus_fetch_fsm.sv ====
module ibus_fetch_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::word_t       pc,
    input  logic                   pc_misaligned,
    input  logic                   halted,
    input  logic                   flush,
    input  logic                   arready,
    input  fetch_pkg::ibus_r_t     r,
    input  logic                   enq_ready,
    output logic                   pc_take,
    output fetch_pkg::ibus_ar_t    ar,
    output logic                   rready,
    output logic                   enq_valid,
    output fetch_pkg::fetch_pair_t enq_pair
);

    typedef enum logic [1:0] {
        st_idle,
        st_address,
        st_data,
        st_hold
    } state_t;

    state_t                 state;
    fetch_pkg::word_t       addr_q;
    fetch_pkg::fetch_pair_t pair_q;
    logic                   stale;
    logic                   start;

    // new work only when idle, not halted, and no redirect this cycle
    assign start   = (state == st_idle) && !halted && !flush;
    assign pc_take = start;

    assign ar.arvalid = (state == st_address);
    assign ar.araddr  = addr_q;
    // data accepted only while waiting for it
    assign rready     = (state == st_data);
    assign enq_valid  = (state == st_hold);
    assign enq_pair   = pair_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            stale <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        // bad pc skips the bus entirely
                        state <= pc_misaligned ? st_hold : st_address;
                    end
                end
                st_address: begin
                    // arvalid cannot be withdrawn, only mark result
                    if (flush) begin
                        stale <= 1'b1;
                    end
                    if (arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (r.rvalid) begin
                        stale <= 1'b0;
                        state <= (stale || flush) ? st_idle : st_hold;
                    end else if (flush) begin
                        stale <= 1'b1;
                    end
                end
                default: begin
                    // held pair dropped on flush
                    if (flush || enq_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // address latch and pair build
    always_ff @(posedge clk) begin
        if (start && !pc_misaligned) begin
            addr_q <= pc;
        end
        if (start && pc_misaligned) begin
            // exception pair, no instructions
            pair_q[0].pc       <= pc;
            pair_q[0].instr    <= '0;
            pair_q[0].addr_exc <= 1'b1;
            pair_q[1].pc       <= pc + 32'd4;
            pair_q[1].instr    <= '0;
            pair_q[1].addr_exc <= 1'b0;
        end else if (rready && r.rvalid) begin
            // low word is slot 0
            pair_q[0].pc       <= addr_q;
            pair_q[0].instr    <= r.rdata[31:0];
            // bus error reported on the leading slot
            pair_q[0].addr_exc <= (r.rresp != 2'b00);
            pair_q[1].pc       <= addr_q + 32'd4;
            pair_q[1].instr    <= r.rdata[63:32];
            pair_q[1].addr_exc <= 1'b0;
        end
    end

    // axi rule, valid held until accepted
    a_arvalid_hold : assert property (@(posedge clk) disable iff (reset)
        ar.arvalid && !arready |=> ar.arvalid);

    a_araddr_stable : assert property (@(posedge clk) disable iff (reset)
        ar.arvalid && !arready |=> $stable(ar.araddr));

endmodule

// ==== hw/pc_select.sv ====
module pc_select #(
    parameter fetch_pkg::word_t RESET_PC  = 32'hbfc0_0000,
    parameter fetch_pkg::word_t EXC_ENTRY = 32'hbfc0_0380
) (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 pc_take,
    output fetch_pkg::word_t     pc,
    output logic                 pc_misaligned,
    output logic                 halted,
    output logic                 flush
);

    fetch_pkg::word_t pc_next;

    // any redirect kills the current fetch path
    assign flush = (redirect.kind != fetch_pkg::redirect_none);

    // word alignment is all the bus needs per slot
    assign pc_misaligned = (pc[1:0] != 2'b00);

    // redirect wins, then sequential step, else hold
    always_comb begin
        pc_next = pc;
        case (redirect.kind)
            fetch_pkg::redirect_branch: begin
                pc_next = redirect.target;
            end
            fetch_pkg::redirect_exception: begin
                // fixed entry, target field ignored
                pc_next = EXC_ENTRY;
            end
            fetch_pkg::redirect_eret: begin
                // target carries epc here
                pc_next = redirect.target;
            end
            default: begin
                if (pc_take) begin
                    pc_next = pc + fetch_pkg::word_t'(fetch_pkg::FETCH_BYTES);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // halt once the bad pc has become an exception pair
    // stays halted until some redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (flush) begin
            halted <= 1'b0;
        end else if (pc_take && pc_misaligned) begin
            halted <= 1'b1;
        end
    end

    // fsm must stay quiet while halted
    a_no_take_halted : assert property (@(posedge clk) disable iff (reset)
        !(pc_take && halted));

    // a consumed pc in a redirect cycle would belong to the old path
    a_no_take_flush : assert property (@(posedge clk) disable iff (reset)
        !(pc_take && flush));

endmodule

// ==== tb/fetch_testdata.txt ====
# opcode value(hex): recv = pairs to take, stall = cycles with out_ready low
# branch / eret = target pc, exc = unused
recv 5
branch 80001000
recv 3
stall 9
recv 4
exc 0
recv 2
eret 80002040
recv 3
branch 80003002
recv 1
stall 14
branch 80004000
recv 3
stall c
recv 3

// ==== tb/tb_fetch_unit.sv ====
module tb_fetch_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam fetch_pkg::word_t RESET_PC    = 32'hbfc0_0000;
    localparam fetch_pkg::word_t EXC_ENTRY   = 32'hbfc0_0380;
    localparam int               QUEUE_DEPTH = 2;
    localparam int               WAIT_LIMIT  = 200;

    logic                   clk = 1'b0;
    logic                   reset;
    fetch_pkg::redirect_t   redirect;
    fetch_pkg::ibus_ar_t    ar;
    logic                   arready;
    fetch_pkg::ibus_r_t     r;
    logic                   rready;
    fetch_pkg::fetch_pair_t out_pair;
    logic                   out_valid;
    logic                   out_ready;

    // expected slot 0 pc of the next pair
    fetch_pkg::word_t exp_pc;
    // set after an exception pair, cleared by a redirect
    logic             exp_halted;

    always #2 clk = ~clk;

    fetch_unit #(
        .RESET_PC   (RESET_PC),
        .EXC_ENTRY  (EXC_ENTRY),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) fetch_unit_i (
        .clk, .reset, .redirect, .ar, .arready, .r, .rready,
        .out_pair, .out_valid, .out_ready
    );

    tb_ibus_model ibus_model_i (
        .clk, .reset, .ar, .arready, .r, .rready
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
        end
    endtask

    // take count pairs, each checked against the pc sequence
    task automatic receive_pairs(input int count);
        int   k;
        int   waited;
        logic exc;
        for (k = 0; k < count; k++) begin
            waited = 0;
            @(negedge clk);
            out_ready = 1'b1;
            while (!out_valid) begin
                if (waited == WAIT_LIMIT) begin
                    report_failure("timed out waiting for an output pair");
                end
                waited++;
                @(negedge clk);
            end
            // misaligned pc gives zeroed instructions, flag on slot 0
            exc = (exp_pc[1:0] != 2'b00);
            check_value("out_pair[0].pc", out_pair[0].pc, exp_pc);
            check_value("out_pair[0].instr", out_pair[0].instr, exc ? 32'h0 : ~exp_pc);
            check_value("out_pair[0].addr_exc", 32'(out_pair[0].addr_exc), 32'(exc));
            check_value("out_pair[1].pc", out_pair[1].pc, exp_pc + 32'd4);
            check_value("out_pair[1].instr", out_pair[1].instr,
                        exc ? 32'h0 : ~(exp_pc + 32'd4));
            check_value("out_pair[1].addr_exc", 32'(out_pair[1].addr_exc), 32'h0);
            exp_halted = exc;
            exp_pc     = exp_pc + 32'd8;
        end
        // last transfer completes at the coming rising edge
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    // output held back, and while halted nothing may show up
    task automatic stall_output(input int cycles);
        out_ready = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (exp_halted && out_valid) begin
                report_failure("a pair appeared while fetch should be halted");
            end
        end
    endtask

    task automatic send_redirect(input fetch_pkg::redirect_kind_t kind,
                                 input fetch_pkg::word_t target);
        @(negedge clk);
        out_ready       = 1'b0;
        redirect.kind   = kind;
        redirect.target = target;
        @(negedge clk);
        redirect.kind   = fetch_pkg::redirect_none;
        redirect.target = '0;
        exp_pc     = (kind == fetch_pkg::redirect_exception) ? EXC_ENTRY : target;
        exp_halted = 1'b0;
    endtask

    task automatic run_command(input string op, input logic [31:0] value);
        if (op == "recv") begin
            receive_pairs(int'(value));
        end else if (op == "stall") begin
            stall_output(int'(value));
        end else if (op == "branch") begin
            send_redirect(fetch_pkg::redirect_branch, value);
        end else if (op == "exc") begin
            send_redirect(fetch_pkg::redirect_exception, value);
        end else if (op == "eret") begin
            send_redirect(fetch_pkg::redirect_eret, value);
        end else begin
            report_failure({"unknown command in data file: ", op});
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        string       op;
        logic [31:0] value;
        exp_pc          = RESET_PC;
        exp_halted      = 1'b0;
        reset           = 1'b1;
        redirect.kind   = fetch_pkg::redirect_none;
        redirect.target = '0;
        out_ready       = 1'b0;
        fd = $fopen("tb/fetch_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("could not open tb/fetch_testdata.txt");
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // bus and output idle out of reset
        check_value("ar.arvalid", 32'(ar.arvalid), 32'h0);
        check_value("rready", 32'(rready), 32'h0);
        check_value("out_valid", 32'(out_valid), 32'h0);
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%s %h", op, value);
                if (fields != 2) begin
                    report_failure({"malformed line in data file: ", line});
                end
                run_command(op, value);
            end
        end
        $fclose(fd);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== tb/tb_ibus_model.sv ====
module tb_ibus_model (
    input  logic                clk,
    input  logic                reset,
    input  fetch_pkg::ibus_ar_t ar,
    output logic                arready,
    output fetch_pkg::ibus_r_t  r,
    input  logic                rready
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        m_idle,
        m_addr_wait,
        m_addr_done,
        m_data_wait,
        m_data_valid
    } phase_t;

    initial begin
        phase_t           phase;
        int unsigned      delay;
        fetch_pkg::word_t addr;
        logic             ready_seen;
        void'($urandom(32263));
        phase      = m_idle;
        delay      = 0;
        addr       = '0;
        ready_seen = 1'b0;
        arready    <= 1'b0;
        r          <= '0;
        forever begin
            @(negedge clk);
            if (reset) begin
                phase = m_idle;
                arready <= 1'b0;
                r       <= '0;
            end else begin
                case (phase)
                    m_idle: begin
                        if (ar.arvalid) begin
                            // araddr is held stable until arready
                            addr  = ar.araddr;
                            delay = $urandom_range(3, 0);
                            phase = m_addr_wait;
                        end
                    end
                    m_addr_wait: begin
                        if (delay == 0) begin
                            arready <= 1'b1;
                            phase = m_addr_done;
                        end else begin
                            delay = delay - 1;
                        end
                    end
                    m_addr_done: begin
                        // AR handshake took place at the last rising edge
                        arready <= 1'b0;
                        delay = $urandom_range(3, 0);
                        phase = m_data_wait;
                    end
                    m_data_wait: begin
                        if (delay == 0) begin
                            // word at x holds ~x
                            r.rvalid <= 1'b1;
                            r.rdata  <= {~(addr + 32'd4), ~addr};
                            r.rresp  <= 2'b00;
                            phase = m_data_valid;
                        end else begin
                            delay = delay - 1;
                        end
                    end
                    default: begin
                        // rready high over the last edge means the beat was taken
                        if (ready_seen) begin
                            r     <= '0;
                            phase = m_idle;
                        end
                    end
                endcase
            end
            ready_seen = rready;
        end
    end

endmodule
